/* include/sd_cmd_config.svh */
/*
 * Build-time constants of the SD command path
 * SD clock divider, response timeout, N_RC gap and bus-switch gap
 */

`ifndef SD_CMD_CONFIG_SVH
`define SD_CMD_CONFIG_SVH

// clk_i cycles per SD bit, even and at least 2
`define SD_CLK_DIV 4

// SD bit periods allowed from the end of bus switch to the response start bit
`define SD_RSP_TIMEOUT 64

// SD bit periods after a response (or a command without one) before the next command
`define SD_NRC 8

// SD bit periods between the command end bit and listening for a response
`define SD_BUS_SWITCH 2

`endif

/* source/sd_cmd_pkg.sv */
/*
 * SD bus side types of the command path
 * response type, sequencer state, command frame, raw response, CRC7 step
 */

`default_nettype none

package sd_cmd_pkg;

  // encoding follows the SDHCI response type select field
  typedef enum logic [1:0] {
    RSP_NONE       = 2'b00,
    RSP_LONG       = 2'b01,
    RSP_SHORT      = 2'b10,
    RSP_SHORT_BUSY = 2'b11
  } rsp_type_e;

  typedef enum logic [2:0] {
    S_READY,   // idle, waiting for a host strobe
    S_WRITE,   // command frame on the CMD line
    S_SWITCH,  // line turnaround
    S_READ,    // waiting for or receiving the response
    S_BUSY,    // card holds DAT0 low after an R1b response
    S_GAP      // N_RC spacing before the next command
  } seq_state_e;

  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] argument;
  } cmd_frame_t;

  // payload holds the bits between direction bit and CRC, LSB last received
  typedef struct packed {
    logic [119:0] payload;
    logic         crc_ok;
    logic         end_bit_ok;
  } raw_rsp_t;

  // serial CRC7, polynomial x^7 + x^3 + 1
  function automatic logic [6:0] crc7_next(logic [6:0] crc, logic bit_in);
    logic fb;
    fb = crc[6] ^ bit_in;
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
  endfunction

endpackage

`default_nettype wire

/* source/sd_host_pkg.sv */
/*
 * Host side types of the command path
 * command request and command result
 */

`default_nettype none

package sd_host_pkg;

  typedef struct packed {
    logic [5:0]            index;
    logic [31:0]           argument;
    sd_cmd_pkg::rsp_type_e rsp_type;
    logic                  crc_check_en;
    logic                  index_check_en;
  } host_cmd_t;

  // rsp_word[0] carries the short response, all four words the long one
  typedef struct packed {
    logic [3:0][31:0] rsp_word;
    logic             timeout_err;
    logic             crc_err;
    logic             end_bit_err;
    logic             index_err;
  } cmd_result_t;

endpackage

`default_nettype wire

/* source/sd_clk_gen.sv */
/*
 * SD clock generator
 * divides clk_i into sd_clk_o and the rising / falling enable pulses
 */

`timescale 1ns/100ps
`default_nettype none
`include "sd_cmd_config.svh"

module sd_clk_gen (
  input  logic clk_i,
  input  logic reset_i,
  output logic sd_clk_o,
  output logic clk_en_p_o,  // high in the cycle before sd_clk rises
  output logic clk_en_n_o   // high in the cycle before sd_clk falls
);

  localparam int unsigned DIV   = `SD_CLK_DIV;
  localparam int unsigned CNT_W = $clog2(DIV);

  logic [CNT_W-1:0] cnt_q;
  logic             sd_clk_q;

  assign clk_en_n_o = (cnt_q == CNT_W'(DIV / 2 - 1));
  assign clk_en_p_o = (cnt_q == CNT_W'(DIV - 1));
  assign sd_clk_o   = sd_clk_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q    <= '0;
      sd_clk_q <= 1'b0;
    end else begin
      // wrap at the end of the SD period
      if (clk_en_p_o) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end

      if (clk_en_p_o) begin
        sd_clk_q <= 1'b1;
      end else if (clk_en_n_o) begin
        sd_clk_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/cmd_write.sv */
/*
 * Command serializer
 * shifts start, direction, index, argument, CRC7 and end bit onto CMD
 */

`timescale 1ns/100ps
`default_nettype none

module cmd_write (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   clk_en_p_i,
  input  logic                   clk_en_n_i,
  input  logic                   start_tx_i,
  input  sd_cmd_pkg::cmd_frame_t frame_i,
  output logic                   cmd_o,
  output logic                   cmd_oe_o,
  output logic                   tx_done_o
);

  logic [39:0] shift_q;
  logic [6:0]  crc_q;
  logic [5:0]  bit_cnt_q;  // bits already driven
  logic        active_q;
  logic        cmd_q;
  logic        oe_q;
  logic        next_bit;

  // content first, then CRC MSB first, then the end bit
  always_comb begin
    if (bit_cnt_q < 6'd40) begin
      next_bit = shift_q[39];
    end else if (bit_cnt_q < 6'd47) begin
      next_bit = crc_q[6];
    end else begin
      next_bit = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q  <= 1'b0;
      bit_cnt_q <= '0;
      cmd_q     <= 1'b1;
      oe_q      <= 1'b0;
    end else if (start_tx_i) begin
      active_q  <= 1'b1;
      bit_cnt_q <= '0;
    end else if (active_q && clk_en_n_i) begin
      if (bit_cnt_q == 6'd48) begin
        // end bit has been sampled, release the line
        active_q <= 1'b0;
        oe_q     <= 1'b0;
        cmd_q    <= 1'b1;
      end else begin
        oe_q      <= 1'b1;
        cmd_q     <= next_bit;
        bit_cnt_q <= bit_cnt_q + 6'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_tx_i) begin
      shift_q <= {1'b0, 1'b1, frame_i.index, frame_i.argument};
      crc_q   <= '0;
    end else if (active_q && clk_en_n_i) begin
      if (bit_cnt_q < 6'd40) begin
        shift_q <= {shift_q[38:0], 1'b0};
        crc_q   <= sd_cmd_pkg::crc7_next(crc_q, shift_q[39]);
      end else begin
        crc_q <= {crc_q[5:0], 1'b0};
      end
    end
  end

  assign cmd_o     = cmd_q;
  assign cmd_oe_o  = oe_q;
  // rising edge on which the card samples the end bit
  assign tx_done_o = active_q && clk_en_p_i && (bit_cnt_q == 6'd48);

  // the sequencer waits for tx_done before it can issue another frame
  assert property (@(posedge clk_i) disable iff (reset_i) start_tx_i |-> !active_q);

endmodule

`default_nettype wire

/* source/rsp_read.sv */
/*
 * Response deserializer
 * start bit detection, 48 or 136 bit capture, CRC7 and end bit check
 */

`timescale 1ns/100ps
`default_nettype none

module rsp_read (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 clk_en_p_i,
  input  logic                 start_listen_i,
  input  logic                 long_rsp_i,
  input  logic                 cmd_i,
  output logic                 receiving_o,
  output logic                 rsp_valid_o,
  output sd_cmd_pkg::raw_rsp_t rsp_o
);

  logic         listening_q;
  logic         receiving_q;
  logic         rsp_valid_q;
  logic         long_q;
  logic [7:0]   pos_q;  // position of the bit on the line, start bit is 0
  logic [119:0] payload_q;
  logic [6:0]   crc_calc_q;
  logic [6:0]   crc_rx_q;
  logic         crc_ok_q;
  logic         end_ok_q;

  logic [7:0]   last_pos;
  logic [7:0]   crc_pos;
  logic         start_seen;
  logic         at_end;
  logic         in_content;
  logic         in_crc_calc;

  always_comb begin
    last_pos    = long_q ? 8'd135 : 8'd47;
    crc_pos     = last_pos - 8'd7;
    start_seen  = clk_en_p_i && listening_q && !receiving_q && !cmd_i;
    at_end      = (pos_q == last_pos);
    in_content  = (pos_q < crc_pos);
    // R2 leaves start, direction and the reserved field out of the CRC
    in_crc_calc = in_content && (!long_q || pos_q >= 8'd8);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      listening_q <= 1'b0;
      receiving_q <= 1'b0;
      rsp_valid_q <= 1'b0;
      pos_q       <= '0;
    end else begin
      rsp_valid_q <= 1'b0;
      if (start_listen_i) begin
        listening_q <= 1'b1;
      end else if (start_seen) begin
        receiving_q <= 1'b1;
        pos_q       <= 8'd1;
      end else if (clk_en_p_i && receiving_q) begin
        pos_q <= pos_q + 8'd1;
        if (at_end) begin
          receiving_q <= 1'b0;
          listening_q <= 1'b0;
          rsp_valid_q <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////
  // shift registers and checks
  ////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (start_listen_i) begin
      long_q <= long_rsp_i;
    end
    if (start_seen) begin
      crc_calc_q <= '0;
    end else if (clk_en_p_i && receiving_q) begin
      if (in_content) begin
        payload_q <= {payload_q[118:0], cmd_i};
      end else if (!at_end) begin
        crc_rx_q <= {crc_rx_q[5:0], cmd_i};
      end
      if (in_crc_calc) begin
        crc_calc_q <= sd_cmd_pkg::crc7_next(crc_calc_q, cmd_i);
      end
      if (at_end) begin
        crc_ok_q <= (crc_rx_q == crc_calc_q);
        end_ok_q <= cmd_i;
      end
    end
  end

  assign receiving_o = receiving_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = '{payload: payload_q, crc_ok: crc_ok_q, end_bit_ok: end_ok_q};

endmodule

`default_nettype wire

/* source/cmd_sequencer.sv */
/*
 * Command sequencer
 * request latch and decode, phase FSM with timing counter, result assembly
 */

`timescale 1ns/100ps
`default_nettype none
`include "sd_cmd_config.svh"

module cmd_sequencer (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     clk_en_p_i,
  input  logic                     cmd_valid_i,
  input  sd_host_pkg::host_cmd_t   cmd_i,
  input  logic                     dat0_i,
  input  logic                     tx_done_i,
  input  logic                     receiving_i,
  input  logic                     rsp_valid_i,
  input  sd_cmd_pkg::raw_rsp_t     rsp_i,
  output logic                     start_tx_o,
  output sd_cmd_pkg::cmd_frame_t   frame_o,
  output logic                     start_listen_o,
  output logic                     long_rsp_o,
  output logic                     cmd_busy_o,
  output logic                     done_o,
  output sd_host_pkg::cmd_result_t result_o
);

  localparam int unsigned CNT_W = 8;
  localparam logic [CNT_W-1:0] SWITCH_LAST  = CNT_W'(`SD_BUS_SWITCH - 1);
  localparam logic [CNT_W-1:0] TIMEOUT_LAST = CNT_W'(`SD_RSP_TIMEOUT - 1);
  localparam logic [CNT_W-1:0] NRC_LAST     = CNT_W'(`SD_NRC - 1);

  sd_cmd_pkg::seq_state_e   state_q, state_d, after_write;
  sd_host_pkg::host_cmd_t   req_q;
  sd_host_pkg::cmd_result_t res_q, rsp_result;
  logic [CNT_W-1:0]         cnt_q;
  logic                     cnt_clr;
  logic                     timeout;
  logic                     accept;
  logic                     start_tx_q;
  logic                     start_listen_q;
  logic                     done_q;

  assign accept = (state_q == sd_cmd_pkg::S_READY) && cmd_valid_i;

  //////////////////////////////
  // decode
  //////////////////////////////

  always_comb begin : decode
    after_write = (req_q.rsp_type == sd_cmd_pkg::RSP_NONE) ? sd_cmd_pkg::S_GAP
                                                           : sd_cmd_pkg::S_SWITCH;
    long_rsp_o  = (req_q.rsp_type == sd_cmd_pkg::RSP_LONG);
  end : decode

  //////////////////////////////
  // execute
  //////////////////////////////

  always_comb begin : next_state
    state_d = state_q;
    timeout = 1'b0;
    unique case (state_q)
      sd_cmd_pkg::S_READY:  if (cmd_valid_i) state_d = sd_cmd_pkg::S_WRITE;
      sd_cmd_pkg::S_WRITE:  if (tx_done_i) state_d = after_write;
      sd_cmd_pkg::S_SWITCH: if (clk_en_p_i && cnt_q == SWITCH_LAST) state_d = sd_cmd_pkg::S_READ;
      sd_cmd_pkg::S_READ: begin
        if (rsp_valid_i) begin
          state_d = (req_q.rsp_type == sd_cmd_pkg::RSP_SHORT_BUSY) ? sd_cmd_pkg::S_BUSY
                                                                   : sd_cmd_pkg::S_GAP;
        end else if (!receiving_i && clk_en_p_i && cnt_q == TIMEOUT_LAST) begin
          // no start bit in time, skip any busy phase
          timeout = 1'b1;
          state_d = sd_cmd_pkg::S_GAP;
        end
      end
      sd_cmd_pkg::S_BUSY:   if (clk_en_p_i && dat0_i) state_d = sd_cmd_pkg::S_GAP;
      sd_cmd_pkg::S_GAP:    if (clk_en_p_i && cnt_q == NRC_LAST) state_d = sd_cmd_pkg::S_READY;
      default:              state_d = sd_cmd_pkg::S_READY;
    endcase
  end : next_state

  // one counter serves switch, timeout and gap; a running reception holds it at 0
  assign cnt_clr = (state_d != state_q) || (state_q == sd_cmd_pkg::S_READ && receiving_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q        <= sd_cmd_pkg::S_READY;
      cnt_q          <= '0;
      start_tx_q     <= 1'b0;
      start_listen_q <= 1'b0;
      done_q         <= 1'b0;
    end else begin
      state_q        <= state_d;
      start_tx_q     <= accept;
      // reader is armed for the whole bus switch
      start_listen_q <= (state_q == sd_cmd_pkg::S_WRITE) && (state_d == sd_cmd_pkg::S_SWITCH);
      done_q         <= (state_q == sd_cmd_pkg::S_GAP) && (state_d == sd_cmd_pkg::S_READY);
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (clk_en_p_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  //////////////////////////////
  // result
  //////////////////////////////

  // word 0 gets SD bits 39:8 of a short response, long fills 127:8
  always_comb begin : result_build
    rsp_result = '0;
    rsp_result.rsp_word[0] = rsp_i.payload[31:0];
    if (req_q.rsp_type == sd_cmd_pkg::RSP_LONG) begin
      rsp_result.rsp_word[1] = rsp_i.payload[63:32];
      rsp_result.rsp_word[2] = rsp_i.payload[95:64];
      rsp_result.rsp_word[3] = {8'h00, rsp_i.payload[119:96]};
    end
    rsp_result.index_err   = req_q.index_check_en && (rsp_i.payload[37:32] != req_q.index);
    rsp_result.crc_err     = req_q.crc_check_en && !rsp_i.crc_ok;
    rsp_result.end_bit_err = !rsp_i.end_bit_ok;
  end : result_build

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= cmd_i;
      res_q <= '0;
    end else if (state_q == sd_cmd_pkg::S_READ && rsp_valid_i) begin
      res_q <= rsp_result;
    end else if (timeout) begin
      res_q.timeout_err <= 1'b1;
    end
  end

  assign start_tx_o     = start_tx_q;
  assign frame_o        = '{index: req_q.index, argument: req_q.argument};
  assign start_listen_o = start_listen_q;
  assign cmd_busy_o     = (state_q != sd_cmd_pkg::S_READY);
  assign done_o         = done_q;
  assign result_o       = res_q;

  // the writer only finishes a frame while the FSM waits for it
  assert property (@(posedge clk_i) disable iff (reset_i)
    tx_done_i |-> (state_q == sd_cmd_pkg::S_WRITE));

  // host keeps to one command at a time
  assert property (@(posedge clk_i) disable iff (reset_i) cmd_valid_i |-> !cmd_busy_o);

endmodule

`default_nettype wire

/* source/sd_cmd_top.sv */
/*
 * SD command path top level
 * clock generator, sequencer, serializer and deserializer
 */

`timescale 1ns/100ps
`default_nettype none

module sd_cmd_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     cmd_valid_i,
  input  sd_host_pkg::host_cmd_t   cmd_i,
  output logic                     cmd_busy_o,
  output logic                     done_o,
  output sd_host_pkg::cmd_result_t result_o,
  output logic                     sd_clk_o,
  input  logic                     sd_cmd_i,
  output logic                     sd_cmd_o,
  output logic                     sd_cmd_oe_o,
  input  logic                     sd_dat0_i
);

  logic                   clk_en_p;
  logic                   clk_en_n;
  logic                   start_tx;
  logic                   tx_done;
  logic                   start_listen;
  logic                   long_rsp;
  logic                   receiving;
  logic                   rsp_valid;
  logic                   rx_line;
  sd_cmd_pkg::cmd_frame_t frame;
  sd_cmd_pkg::raw_rsp_t   rsp;

  // the reader sees an idle line while the host drives CMD
  assign rx_line = sd_cmd_i | sd_cmd_oe_o;

  sd_clk_gen u_clk_gen (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .sd_clk_o   (sd_clk_o),
    .clk_en_p_o (clk_en_p),
    .clk_en_n_o (clk_en_n)
  );

  cmd_sequencer u_sequencer (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .clk_en_p_i     (clk_en_p),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_i          (cmd_i),
    .dat0_i         (sd_dat0_i),
    .tx_done_i      (tx_done),
    .receiving_i    (receiving),
    .rsp_valid_i    (rsp_valid),
    .rsp_i          (rsp),
    .start_tx_o     (start_tx),
    .frame_o        (frame),
    .start_listen_o (start_listen),
    .long_rsp_o     (long_rsp),
    .cmd_busy_o     (cmd_busy_o),
    .done_o         (done_o),
    .result_o       (result_o)
  );

  cmd_write u_cmd_write (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .clk_en_p_i (clk_en_p),
    .clk_en_n_i (clk_en_n),
    .start_tx_i (start_tx),
    .frame_i    (frame),
    .cmd_o      (sd_cmd_o),
    .cmd_oe_o   (sd_cmd_oe_o),
    .tx_done_o  (tx_done)
  );

  rsp_read u_rsp_read (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .clk_en_p_i     (clk_en_p),
    .start_listen_i (start_listen),
    .long_rsp_i     (long_rsp),
    .cmd_i          (rx_line),
    .receiving_o    (receiving),
    .rsp_valid_o    (rsp_valid),
    .rsp_o          (rsp)
  );

endmodule

`default_nettype wire

/* bench/sd_card_model.sv */
/*
 * Behavioral SD card for the command path bench
 * open-drain CMD line with pull-up, frame capture with CRC7 recompute,
 * programmable response with faults, DAT0 busy
 */

`timescale 1ns/100ps
`default_nettype none

module sd_card_model (
  input  logic                  sd_clk_i,
  input  logic                  host_cmd_i,
  input  logic                  host_oe_i,
  input  sd_cmd_pkg::rsp_type_e rsp_type_i,
  input  logic [5:0]            rsp_index_i,
  input  logic [119:0]          rsp_payload_i,
  input  logic                  bad_crc_i,
  input  logic                  bad_end_i,
  input  logic                  silent_i,
  input  int                    busy_len_i,  // DAT0 low time in SD bit periods
  output logic                  cmd_line_o,
  output logic                  dat0_o,
  output logic [47:0]           frame_o,
  output logic [6:0]            frame_crc_o,
  output int                    frame_cnt_o
);

  logic drive_low;

  // pull-up, host and card can only pull the line low
  assign cmd_line_o = !((host_oe_i === 1'b1 && host_cmd_i === 1'b0) || drive_low);

  // x^7 + x^3 + 1 over the low nbits of data, MSB first
  function automatic logic [6:0] crc7_of(logic [135:0] data, int nbits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = nbits - 1; i >= 0; i--) begin
      fb  = crc[6] ^ data[i];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  task automatic capture_frame();
    logic [47:0] bits;
    bits = '0;  // start bit already seen
    for (int i = 46; i >= 0; i--) begin
      @(posedge sd_clk_i);
      bits[i] = cmd_line_o;
    end
    frame_o     = bits;
    frame_crc_o = crc7_of(136'(bits[47:8]), 40);
    frame_cnt_o = frame_cnt_o + 1;
  endtask

  task automatic send_response();
    logic [135:0] bits;
    logic [39:0]  content;
    int           len;
    logic         busy;
    busy = (rsp_type_i == sd_cmd_pkg::RSP_SHORT_BUSY) && (busy_len_i > 0);
    if (rsp_type_i == sd_cmd_pkg::RSP_LONG) begin
      // R2: start, direction, reserved ones, CID/CSD, CRC over CID/CSD only
      len  = 136;
      bits = {2'b00, 6'h3f, rsp_payload_i, crc7_of(136'(rsp_payload_i), 120), 1'b1};
    end else begin
      len     = 48;
      content = {2'b00, rsp_index_i, rsp_payload_i[31:0]};
      bits    = 136'({content, crc7_of(136'(content), 40), 1'b1});
    end
    if (bad_crc_i) begin
      bits[1] = !bits[1];
    end
    if (bad_end_i) begin
      bits[0] = 1'b0;
    end
    // N_CR before the start bit
    repeat (2) @(posedge sd_clk_i);
    for (int i = len - 1; i >= 0; i--) begin
      @(negedge sd_clk_i);
      drive_low = !bits[i];
    end
    if (busy) begin
      dat0_o = 1'b0;
    end
    @(negedge sd_clk_i);
    drive_low = 1'b0;
    if (busy) begin
      repeat (busy_len_i) @(negedge sd_clk_i);
      dat0_o = 1'b1;
    end
  endtask

  initial begin
    drive_low   = 1'b0;
    dat0_o      = 1'b1;
    frame_o     = '0;
    frame_crc_o = '0;
    frame_cnt_o = 0;
    forever begin
      @(posedge sd_clk_i);
      if (cmd_line_o === 1'b0) begin
        capture_frame();
        if (rsp_type_i != sd_cmd_pkg::RSP_NONE && !silent_i) begin
          send_response();
        end
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_sd_cmd.sv */
/*
 * Testbench of the SD command path
 * clock and reset, behavioral card, directed command tests, final report
 */

`timescale 1ns/100ps
`default_nettype none
`include "sd_cmd_config.svh"

module tb_sd_cmd;

  // worst case: frame, switch, full timeout, long response, busy, gap
  localparam int DONE_TIMEOUT =
    (48 + `SD_BUS_SWITCH + `SD_RSP_TIMEOUT + 136 + 64 + `SD_NRC) * `SD_CLK_DIV * 2;
  localparam int BUSY_T = 20;

  logic                     clk;
  logic                     reset;
  logic                     cmd_valid;
  sd_host_pkg::host_cmd_t   cmd;
  logic                     cmd_busy;
  logic                     done;
  sd_host_pkg::cmd_result_t result;
  logic                     sd_clk;
  logic                     cmd_line;
  logic                     host_cmd;
  logic                     host_oe;
  logic                     dat0;

  // card programming and capture
  sd_cmd_pkg::rsp_type_e    card_type;
  logic [5:0]               card_index;
  logic [119:0]             card_payload;
  logic                     card_bad_crc;
  logic                     card_bad_end;
  logic                     card_silent;
  int                       card_busy_len;
  logic [47:0]              card_frame;
  logic [6:0]               card_crc;
  int                       card_frame_cnt;

  sd_host_pkg::cmd_result_t res;
  logic                     saw_dat0_low;
  int                       checks;
  int                       errors;

  sd_cmd_top u_dut (
    .clk_i       (clk),
    .reset_i     (reset),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_busy_o  (cmd_busy),
    .done_o      (done),
    .result_o    (result),
    .sd_clk_o    (sd_clk),
    .sd_cmd_i    (cmd_line),
    .sd_cmd_o    (host_cmd),
    .sd_cmd_oe_o (host_oe),
    .sd_dat0_i   (dat0)
  );

  sd_card_model u_card (
    .sd_clk_i      (sd_clk),
    .host_cmd_i    (host_cmd),
    .host_oe_i     (host_oe),
    .rsp_type_i    (card_type),
    .rsp_index_i   (card_index),
    .rsp_payload_i (card_payload),
    .bad_crc_i     (card_bad_crc),
    .bad_end_i     (card_bad_end),
    .silent_i      (card_silent),
    .busy_len_i    (card_busy_len),
    .cmd_line_o    (cmd_line),
    .dat0_o        (dat0),
    .frame_o       (card_frame),
    .frame_crc_o   (card_crc),
    .frame_cnt_o   (card_frame_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [5:0] random_index();
    return 6'($urandom() % 32'd63 + 32'd1);
  endfunction

  function automatic logic [119:0] random_payload();
    logic [127:0] wide;
    wide = {$urandom(), $urandom(), $urandom(), $urandom()};
    return wide[119:0];
  endfunction

  task automatic program_card(input sd_cmd_pkg::rsp_type_e rtype, input logic [5:0] idx,
                              input logic [119:0] payload, input logic bad_crc,
                              input logic bad_end, input logic silent, input int busy_len);
    card_type     = rtype;
    card_index    = idx;
    card_payload  = payload;
    card_bad_crc  = bad_crc;
    card_bad_end  = bad_end;
    card_silent   = silent;
    card_busy_len = busy_len;
  endtask

  task automatic issue_command(input logic [5:0] idx, input logic [31:0] arg,
                               input sd_cmd_pkg::rsp_type_e rtype, input logic crc_en,
                               input logic idx_en);
    @(negedge clk);
    cmd.index          = idx;
    cmd.argument       = arg;
    cmd.rsp_type       = rtype;
    cmd.crc_check_en   = crc_en;
    cmd.index_check_en = idx_en;
    cmd_valid          = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // busy must hold until done_o, and fall in the done_o cycle
  task automatic wait_for_done();
    int   cycles;
    logic seen;
    seen         = 1'b0;
    cycles       = 0;
    saw_dat0_low = 1'b0;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (dat0 === 1'b0) begin
        saw_dat0_low = 1'b1;
      end
      if (done === 1'b1) begin
        seen = 1'b1;
        res  = result;
        compare_value("cmd_busy_o", cmd_busy, 0);
        if (dat0 !== 1'b1) begin
          errors++;
          $display("done_o pulsed at %0t ns while DAT0 was still held low", $time);
        end
      end else if (cmd_busy !== 1'b1) begin
        compare_value("cmd_busy_o", cmd_busy, 1);
      end
    end
    if (!seen) begin
      errors++;
      $display("timeout: no done_o within %0d cycles at %0t ns", DONE_TIMEOUT, $time);
    end else begin
      @(negedge clk);
      compare_value("done_o", done, 0);
    end
  endtask

  task automatic check_frame(input logic [5:0] idx, input logic [31:0] arg);
    compare_value("frame start bit", card_frame[47], 0);
    compare_value("frame direction bit", card_frame[46], 1);
    compare_value("frame index", card_frame[45:40], idx);
    compare_value("frame argument", card_frame[39:8], arg);
    compare_value("frame crc7", card_frame[7:1], card_crc);
    compare_value("frame end bit", card_frame[0], 1);
  endtask

  task automatic run_command(input logic [5:0] idx, input logic [31:0] arg,
                             input sd_cmd_pkg::rsp_type_e rtype, input logic crc_en,
                             input logic idx_en);
    int frames_before;
    frames_before = card_frame_cnt;
    issue_command(idx, arg, rtype, crc_en, idx_en);
    wait_for_done();
    compare_value("card frame count", card_frame_cnt, frames_before + 1);
    check_frame(idx, arg);
  endtask

  task automatic check_flags(input logic t, input logic c, input logic e, input logic i);
    compare_value("result_o.timeout_err", res.timeout_err, t);
    compare_value("result_o.crc_err", res.crc_err, c);
    compare_value("result_o.end_bit_err", res.end_bit_err, e);
    compare_value("result_o.index_err", res.index_err, i);
  endtask

  task automatic check_reset_values();
    compare_value("sd_cmd_oe_o", host_oe, 0);
    compare_value("sd_cmd_o", host_cmd, 1);
    compare_value("cmd_busy_o", cmd_busy, 0);
    compare_value("done_o", done, 0);
    compare_value("sd_clk_o", sd_clk, 0);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic send_no_response();
    program_card(sd_cmd_pkg::RSP_NONE, 6'd0, '0, 1'b0, 1'b0, 1'b0, 0);
    run_command(6'd0, 32'h0, sd_cmd_pkg::RSP_NONE, 1'b1, 1'b1);
    // CMD0 with a zero argument has the well-known CRC7 0x4a
    compare_value("frame crc7 of CMD0", card_frame[7:1], 7'h4a);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
    run_command(random_index(), $urandom(), sd_cmd_pkg::RSP_NONE, 1'b1, 1'b1);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic read_short_response();
    logic [5:0]   idx;
    logic [119:0] p;
    idx = random_index();
    p   = random_payload();
    program_card(sd_cmd_pkg::RSP_SHORT, idx, p, 1'b0, 1'b0, 1'b0, 0);
    run_command(idx, $urandom(), sd_cmd_pkg::RSP_SHORT, 1'b1, 1'b1);
    compare_value("result_o.rsp_word[0]", res.rsp_word[0], p[31:0]);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic read_long_response();
    logic [119:0] p;
    p = random_payload();
    program_card(sd_cmd_pkg::RSP_LONG, 6'h3f, p, 1'b0, 1'b0, 1'b0, 0);
    run_command(random_index(), $urandom(), sd_cmd_pkg::RSP_LONG, 1'b1, 1'b0);
    compare_value("result_o.rsp_word[0]", res.rsp_word[0], p[31:0]);
    compare_value("result_o.rsp_word[1]", res.rsp_word[1], p[63:32]);
    compare_value("result_o.rsp_word[2]", res.rsp_word[2], p[95:64]);
    compare_value("result_o.rsp_word[3][23:0]", res.rsp_word[3][23:0], p[119:96]);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic inject_faults();
    logic [5:0]   idx;
    logic [119:0] p;
    idx = random_index();
    p   = random_payload();
    // corrupted CRC, reported only with crc_check_en
    program_card(sd_cmd_pkg::RSP_SHORT, idx, p, 1'b1, 1'b0, 1'b0, 0);
    run_command(idx, $urandom(), sd_cmd_pkg::RSP_SHORT, 1'b1, 1'b1);
    check_flags(1'b0, 1'b1, 1'b0, 1'b0);
    run_command(idx, $urandom(), sd_cmd_pkg::RSP_SHORT, 1'b0, 1'b1);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
    program_card(sd_cmd_pkg::RSP_SHORT, idx, p, 1'b0, 1'b1, 1'b0, 0);
    run_command(idx, $urandom(), sd_cmd_pkg::RSP_SHORT, 1'b1, 1'b1);
    check_flags(1'b0, 1'b0, 1'b1, 1'b0);
    // wrong index, reported only with index_check_en
    program_card(sd_cmd_pkg::RSP_SHORT, idx ^ 6'h01, p, 1'b0, 1'b0, 1'b0, 0);
    run_command(idx, $urandom(), sd_cmd_pkg::RSP_SHORT, 1'b1, 1'b1);
    check_flags(1'b0, 1'b0, 1'b0, 1'b1);
    run_command(idx, $urandom(), sd_cmd_pkg::RSP_SHORT, 1'b1, 1'b0);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic silent_card_timeout();
    logic [5:0] idx;
    idx = random_index();
    program_card(sd_cmd_pkg::RSP_SHORT, idx, random_payload(), 1'b0, 1'b0, 1'b1, 0);
    run_command(idx, $urandom(), sd_cmd_pkg::RSP_SHORT, 1'b1, 1'b1);
    check_flags(1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic r1b_busy_wait();
    logic [5:0]   idx;
    logic [119:0] p;
    idx = random_index();
    p   = random_payload();
    program_card(sd_cmd_pkg::RSP_SHORT_BUSY, idx, p, 1'b0, 1'b0, 1'b0, BUSY_T);
    run_command(idx, $urandom(), sd_cmd_pkg::RSP_SHORT_BUSY, 1'b1, 1'b1);
    checks++;
    if (!saw_dat0_low) begin
      errors++;
      $display("DAT0 busy was never seen before done_o at %0t ns", $time);
    end
    compare_value("result_o.rsp_word[0]", res.rsp_word[0], p[31:0]);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  initial begin
    void'($urandom(65482));
    checks     = 0;
    errors     = 0;
    reset      = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    program_card(sd_cmd_pkg::RSP_NONE, 6'd0, '0, 1'b0, 1'b0, 1'b0, 0);
    repeat (10) @(negedge clk);
    check_reset_values();
    reset = 1'b0;
    repeat (4) @(negedge clk);

    send_no_response();
    read_short_response();
    read_long_response();
    inject_faults();
    silent_card_timeout();
    r1b_busy_wait();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
source/sd_cmd_pkg.sv
source/sd_host_pkg.sv
source/sd_clk_gen.sv
source/cmd_write.sv
source/rsp_read.sv
source/cmd_sequencer.sv
source/sd_cmd_top.sv
bench/sd_card_model.sv
bench/tb_sd_cmd.sv

/* Bender.yml */
package:
  name: sd_cmd

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/sd_cmd_pkg.sv
      - source/sd_host_pkg.sv
      - source/sd_clk_gen.sv
      - source/cmd_write.sv
      - source/rsp_read.sv
      - source/cmd_sequencer.sv
      - source/sd_cmd_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/sd_card_model.sv
      - bench/tb_sd_cmd.sv
